// ==== verilog/rv_decode_pkg.sv ====
// shared widths, types, opcode field layout and decode codes, imported by every rv64 front end module
`default_nettype none

package rv_decode_pkg;

    localparam int XLEN      = 64;                 // data and pc width
    localparam int ILEN      = 32;                 // instruction word
    localparam int REG_IDX_W = 5;
    localparam int OPCODE_W  = 24;                 // grouped opcode vector
    localparam int IMM_FMT_W = 3;

    typedef logic [XLEN-1:0]      xlen_t;
    typedef logic [ILEN-1:0]      inst_t;
    typedef logic [OPCODE_W-1:0]  opcode_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [IMM_FMT_W-1:0] imm_fmt_t;

    localparam imm_fmt_t IMM_NONE = 3'd0;          // no immediate, gives 0
    localparam imm_fmt_t IMM_I    = 3'd1;
    localparam imm_fmt_t IMM_S    = 3'd2;
    localparam imm_fmt_t IMM_B    = 3'd3;
    localparam imm_fmt_t IMM_U    = 3'd4;
    localparam imm_fmt_t IMM_J    = 3'd5;

    localparam xlen_t RESET_PC = 64'h8000_0000;
    localparam inst_t INST_NOP = 32'h0000_0000;    // what decode sees for an empty slot

    // field placement inside opcode_t, zero in a field means no match
    localparam int OPF_IMM_MEM_LSB = 0;
    localparam int OPF_IMM_MEM_W   = 7;
    localparam int OPF_EBREAK      = 7;            // single bit
    localparam int OPF_UPPER_LSB   = 8;
    localparam int OPF_UPPER_W     = 2;
    localparam int OPF_SHIFTI_LSB  = 10;
    localparam int OPF_SHIFTI_W    = 2;
    localparam int OPF_REG_LSB     = 12;
    localparam int OPF_REG_W       = 8;
    localparam int OPF_SYS_LSB     = 20;
    localparam int OPF_SYS_W       = 4;

    localparam logic [6:0] OPC_LOAD     = 7'b0000011;   // major opcodes
    localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
    localparam logic [6:0] OPC_OP_IMM32 = 7'b0011011;
    localparam logic [6:0] OPC_STORE    = 7'b0100011;
    localparam logic [6:0] OPC_OP       = 7'b0110011;
    localparam logic [6:0] OPC_LUI      = 7'b0110111;
    localparam logic [6:0] OPC_OP32     = 7'b0111011;
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

    localparam inst_t INST_ECALL  = 32'h0000_0073;     // full-word system matches
    localparam inst_t INST_EBREAK = 32'h0010_0073;
    localparam inst_t INST_MRET   = 32'h3020_0073;

    localparam logic [6:0] OP_JALR  = 7'd4;        // imm / mem group
    localparam logic [6:0] OP_BEQ   = 7'd5;
    localparam logic [6:0] OP_BNE   = 7'd6;
    localparam logic [6:0] OP_BLT   = 7'd7;
    localparam logic [6:0] OP_BGE   = 7'd8;
    localparam logic [6:0] OP_BLTU  = 7'd9;
    localparam logic [6:0] OP_BGEU  = 7'd10;
    localparam logic [6:0] OP_LB    = 7'd11;
    localparam logic [6:0] OP_LH    = 7'd12;
    localparam logic [6:0] OP_LW    = 7'd13;
    localparam logic [6:0] OP_LBU   = 7'd14;
    localparam logic [6:0] OP_LHU   = 7'd15;
    localparam logic [6:0] OP_SB    = 7'd16;
    localparam logic [6:0] OP_SH    = 7'd17;
    localparam logic [6:0] OP_SW    = 7'd18;
    localparam logic [6:0] OP_ADDI  = 7'd19;
    localparam logic [6:0] OP_SLTI  = 7'd20;
    localparam logic [6:0] OP_SLTIU = 7'd21;
    localparam logic [6:0] OP_XORI  = 7'd22;
    localparam logic [6:0] OP_ORI   = 7'd23;
    localparam logic [6:0] OP_ANDI  = 7'd24;
    localparam logic [6:0] OP_LWU   = 7'd41;
    localparam logic [6:0] OP_LD    = 7'd42;
    localparam logic [6:0] OP_SD    = 7'd43;
    localparam logic [6:0] OP_ADDIW = 7'd47;
    localparam logic [6:0] OP_CSRRW = 7'd49;
    localparam logic [6:0] OP_CSRRS = 7'd50;

    localparam logic [1:0] UP_LUI   = 2'd1;        // upper group
    localparam logic [1:0] UP_AUIPC = 2'd2;
    localparam logic [1:0] UP_JAL   = 2'd3;

    localparam logic [1:0] SH_SLLI = 2'd1;         // immediate shifts
    localparam logic [1:0] SH_SRLI = 2'd2;
    localparam logic [1:0] SH_SRAI = 2'd3;

    localparam logic [7:0] REG_ADD   = 8'h04;      // register group, gaps kept from old numbering
    localparam logic [7:0] REG_SUB   = 8'h05;
    localparam logic [7:0] REG_SLL   = 8'h06;
    localparam logic [7:0] REG_SLT   = 8'h07;
    localparam logic [7:0] REG_SLTU  = 8'h08;
    localparam logic [7:0] REG_XOR   = 8'h09;
    localparam logic [7:0] REG_SRL   = 8'h10;
    localparam logic [7:0] REG_OR    = 8'h12;
    localparam logic [7:0] REG_AND   = 8'h13;
    localparam logic [7:0] REG_SLLIW = 8'h14;
    localparam logic [7:0] REG_SRLIW = 8'h15;
    localparam logic [7:0] REG_SRAIW = 8'h16;
    localparam logic [7:0] REG_ADDW  = 8'h17;
    localparam logic [7:0] REG_SUBW  = 8'h18;
    localparam logic [7:0] REG_SLLW  = 8'h19;
    localparam logic [7:0] REG_SRLW  = 8'h1a;
    localparam logic [7:0] REG_SRAW  = 8'h1b;
    localparam logic [7:0] REG_MUL   = 8'h1d;
    localparam logic [7:0] REG_DIV   = 8'h21;
    localparam logic [7:0] REG_DIVU  = 8'h22;
    localparam logic [7:0] REG_REMU  = 8'h24;
    localparam logic [7:0] REG_MULW  = 8'h25;
    localparam logic [7:0] REG_DIVW  = 8'h26;
    localparam logic [7:0] REG_DIVUW = 8'h27;
    localparam logic [7:0] REG_REMW  = 8'h28;
    localparam logic [7:0] REG_REMUW = 8'h29;

    localparam logic [3:0] SYS_ECALL = 4'd2;       // system group
    localparam logic [3:0] SYS_MRET  = 4'd5;

endpackage

`default_nettype wire

// ==== verilog/fetch_stage.sv ====
// program counter for the fetch stage, drives the instruction memory address
`timescale 1ns/100ps
`default_nettype none

module fetch_stage import rv_decode_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  redirect,      // level from execute, sampled at the edge
    input  xlen_t redirect_pc,
    output xlen_t pc             // also the imem address
);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (redirect) begin
            pc <= redirect_pc;   // redirect wins over sequential
        end else begin
            pc <= pc + 64'd4;
        end
    end

    // execute must only ever hand back word-aligned targets
    assert property (@(posedge clk) disable iff (rst)
        redirect |-> (redirect_pc[1:0] == 2'b00))
        else $error("fetch_stage: misaligned redirect target %h", redirect_pc);

    // pc stays aligned across any mix of increments and redirects
    assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
        else $error("fetch_stage: misaligned pc %h", pc);

endmodule

`default_nettype wire

// ==== verilog/inst_decoder.sv ====
// combinational classifier of one instruction word into the grouped opcode vector and illegal flag
`timescale 1ns/100ps
`default_nettype none

module inst_decoder import rv_decode_pkg::*; (
    input  inst_t   inst,
    output opcode_t opcode,
    output logic    illegal
);

    logic [OPF_IMM_MEM_W-1:0] f_imm_mem;
    logic                     f_ebreak;
    logic [OPF_UPPER_W-1:0]   f_upper;
    logic [OPF_SHIFTI_W-1:0]  f_shifti;
    logic [OPF_REG_W-1:0]     f_reg;
    logic [OPF_SYS_W-1:0]     f_sys;

    // one block so all groups settle together
    always_comb begin
        case ({inst[14:12], inst[6:0]})                 // funct3 + major
            {3'b000, OPC_JALR}:     f_imm_mem = OP_JALR;
            {3'b000, OPC_BRANCH}:   f_imm_mem = OP_BEQ;
            {3'b001, OPC_BRANCH}:   f_imm_mem = OP_BNE;
            {3'b100, OPC_BRANCH}:   f_imm_mem = OP_BLT;
            {3'b101, OPC_BRANCH}:   f_imm_mem = OP_BGE;
            {3'b110, OPC_BRANCH}:   f_imm_mem = OP_BLTU;
            {3'b111, OPC_BRANCH}:   f_imm_mem = OP_BGEU;
            {3'b000, OPC_LOAD}:     f_imm_mem = OP_LB;
            {3'b001, OPC_LOAD}:     f_imm_mem = OP_LH;
            {3'b010, OPC_LOAD}:     f_imm_mem = OP_LW;
            {3'b100, OPC_LOAD}:     f_imm_mem = OP_LBU;
            {3'b101, OPC_LOAD}:     f_imm_mem = OP_LHU;
            {3'b110, OPC_LOAD}:     f_imm_mem = OP_LWU;
            {3'b011, OPC_LOAD}:     f_imm_mem = OP_LD;
            {3'b000, OPC_STORE}:    f_imm_mem = OP_SB;
            {3'b001, OPC_STORE}:    f_imm_mem = OP_SH;
            {3'b010, OPC_STORE}:    f_imm_mem = OP_SW;
            {3'b011, OPC_STORE}:    f_imm_mem = OP_SD;
            {3'b000, OPC_OP_IMM}:   f_imm_mem = OP_ADDI;
            {3'b010, OPC_OP_IMM}:   f_imm_mem = OP_SLTI;
            {3'b011, OPC_OP_IMM}:   f_imm_mem = OP_SLTIU;
            {3'b100, OPC_OP_IMM}:   f_imm_mem = OP_XORI;
            {3'b110, OPC_OP_IMM}:   f_imm_mem = OP_ORI;
            {3'b111, OPC_OP_IMM}:   f_imm_mem = OP_ANDI;
            {3'b000, OPC_OP_IMM32}: f_imm_mem = OP_ADDIW;
            {3'b001, OPC_SYSTEM}:   f_imm_mem = OP_CSRRW;
            {3'b010, OPC_SYSTEM}:   f_imm_mem = OP_CSRRS;
            default:                f_imm_mem = '0;
        endcase

        case (inst)                                     // exact words only
            INST_ECALL: f_sys = SYS_ECALL;
            INST_MRET:  f_sys = SYS_MRET;
            default:    f_sys = '0;
        endcase

        case (inst[6:0])
            OPC_LUI:   f_upper = UP_LUI;
            OPC_AUIPC: f_upper = UP_AUIPC;
            OPC_JAL:   f_upper = UP_JAL;
            default:   f_upper = '0;
        endcase

        case ({inst[31:25], inst[14:12], inst[6:0]})    // funct7 + funct3 + major
            {7'b0000000, 3'b000, OPC_OP}:       f_reg = REG_ADD;
            {7'b0100000, 3'b000, OPC_OP}:       f_reg = REG_SUB;
            {7'b0000000, 3'b001, OPC_OP}:       f_reg = REG_SLL;
            {7'b0000000, 3'b010, OPC_OP}:       f_reg = REG_SLT;
            {7'b0000000, 3'b011, OPC_OP}:       f_reg = REG_SLTU;
            {7'b0000000, 3'b100, OPC_OP}:       f_reg = REG_XOR;
            {7'b0000000, 3'b101, OPC_OP}:       f_reg = REG_SRL;
            {7'b0000000, 3'b110, OPC_OP}:       f_reg = REG_OR;
            {7'b0000000, 3'b111, OPC_OP}:       f_reg = REG_AND;
            {7'b0000000, 3'b001, OPC_OP_IMM32}: f_reg = REG_SLLIW;   // w shifts live here
            {7'b0000000, 3'b101, OPC_OP_IMM32}: f_reg = REG_SRLIW;
            {7'b0100000, 3'b101, OPC_OP_IMM32}: f_reg = REG_SRAIW;
            {7'b0000000, 3'b000, OPC_OP32}:     f_reg = REG_ADDW;
            {7'b0100000, 3'b000, OPC_OP32}:     f_reg = REG_SUBW;
            {7'b0000000, 3'b001, OPC_OP32}:     f_reg = REG_SLLW;
            {7'b0000000, 3'b101, OPC_OP32}:     f_reg = REG_SRLW;
            {7'b0100000, 3'b101, OPC_OP32}:     f_reg = REG_SRAW;
            {7'b0000001, 3'b000, OPC_OP}:       f_reg = REG_MUL;     // m extension
            {7'b0000001, 3'b100, OPC_OP}:       f_reg = REG_DIV;
            {7'b0000001, 3'b101, OPC_OP}:       f_reg = REG_DIVU;
            {7'b0000001, 3'b111, OPC_OP}:       f_reg = REG_REMU;
            {7'b0000001, 3'b000, OPC_OP32}:     f_reg = REG_MULW;
            {7'b0000001, 3'b100, OPC_OP32}:     f_reg = REG_DIVW;
            {7'b0000001, 3'b101, OPC_OP32}:     f_reg = REG_DIVUW;
            {7'b0000001, 3'b110, OPC_OP32}:     f_reg = REG_REMW;
            {7'b0000001, 3'b111, OPC_OP32}:     f_reg = REG_REMUW;
            default:                            f_reg = '0;
        endcase

        case ({inst[31:26], inst[14:12], inst[6:0]})    // rv64 shamt is 6 bits
            {6'b000000, 3'b001, OPC_OP_IMM}: f_shifti = SH_SLLI;
            {6'b000000, 3'b101, OPC_OP_IMM}: f_shifti = SH_SRLI;
            {6'b010000, 3'b101, OPC_OP_IMM}: f_shifti = SH_SRAI;
            default:                         f_shifti = '0;
        endcase

        f_ebreak = (inst == INST_EBREAK);

        opcode = '0;
        opcode[OPF_IMM_MEM_LSB +: OPF_IMM_MEM_W] = f_imm_mem;
        opcode[OPF_EBREAK]                       = f_ebreak;
        opcode[OPF_UPPER_LSB +: OPF_UPPER_W]     = f_upper;
        opcode[OPF_SHIFTI_LSB +: OPF_SHIFTI_W]   = f_shifti;
        opcode[OPF_REG_LSB +: OPF_REG_W]         = f_reg;
        opcode[OPF_SYS_LSB +: OPF_SYS_W]         = f_sys;

        // the six group tables are disjoint
        assert ($onehot0({|f_imm_mem, f_ebreak, |f_upper, |f_shifti, |f_reg, |f_sys}))
            else $error("inst_decoder: %h matched in more than one group", inst);
    end

    assign illegal = (inst != INST_NOP) && (opcode == '0);   // empty slot is never illegal

endmodule

`default_nettype wire

// ==== verilog/imm_gen.sv ====
// immediate builder, picks the format from the major opcode and sign extends to 64 bits
`timescale 1ns/100ps
`default_nettype none

module imm_gen import rv_decode_pkg::*; (
    input  inst_t inst,
    output xlen_t imm
);

    imm_fmt_t fmt;
    logic     sgn;

    assign sgn = inst[31];       // every format signs from bit 31

    always_comb begin
        case (inst[6:0])
            OPC_JALR, OPC_LOAD, OPC_OP_IMM, OPC_OP_IMM32: fmt = IMM_I;   // shifts too
            OPC_STORE:                                    fmt = IMM_S;
            OPC_BRANCH:                                   fmt = IMM_B;
            OPC_LUI, OPC_AUIPC:                           fmt = IMM_U;
            OPC_JAL:                                      fmt = IMM_J;
            default:                                      fmt = IMM_NONE;
        endcase
    end

    always_comb begin
        case (fmt)
            IMM_I:   imm = {{52{sgn}}, inst[31:20]};
            IMM_S:   imm = {{52{sgn}}, inst[31:25], inst[11:7]};
            IMM_B:   imm = {{51{sgn}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            IMM_U:   imm = {{32{sgn}}, inst[31:12], 12'b0};
            IMM_J:   imm = {{43{sgn}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            default: imm = '0;   // r-type, system, empty slot
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/id_stage.sv ====
// decode stage register with squash, feeds the decoder and immediate generator
`timescale 1ns/100ps
`default_nettype none

module id_stage import rv_decode_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     redirect,
    input  xlen_t    if_pc,
    input  inst_t    if_inst,
    output logic     id_valid,
    output xlen_t    id_pc,
    output inst_t    id_inst,
    output opcode_t  opcode,
    output logic     illegal,
    output reg_idx_t rd,
    output reg_idx_t rs1,
    output reg_idx_t rs2,
    output xlen_t    imm
);

    logic  valid_q;
    xlen_t pc_q;
    inst_t inst_q;
    inst_t dec_inst;             // word actually decoded

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
            pc_q    <= '0;
            inst_q  <= '0;
        end else begin
            valid_q <= !redirect;   // wrong-path slot dropped
            pc_q    <= if_pc;
            inst_q  <= if_inst;
        end
    end

    assign dec_inst = valid_q ? inst_q : INST_NOP;

    assign id_valid = valid_q;
    assign id_pc    = pc_q;      // raw register, even when invalid
    assign id_inst  = inst_q;

    assign rd  = dec_inst[11:7];
    assign rs1 = dec_inst[19:15];
    assign rs2 = dec_inst[24:20];

    inst_decoder u_decoder (
        .inst    (dec_inst),
        .opcode  (opcode),
        .illegal (illegal)
    );

    imm_gen u_imm_gen (
        .inst (dec_inst),
        .imm  (imm)
    );

    // slot fetched under a redirect must not show as valid
    assert property (@(posedge clk) disable iff (rst) redirect |=> !id_valid)
        else $error("id_stage: squashed slot still valid");

endmodule

`default_nettype wire

// ==== verilog/decode_top.sv ====
// front end top level joining fetch and decode to the imem and execute ports
`timescale 1ns/100ps
`default_nettype none

module decode_top import rv_decode_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    output xlen_t    imem_addr,
    input  inst_t    imem_data,      // same-cycle read
    input  logic     redirect,
    input  xlen_t    redirect_pc,
    output logic     id_valid,
    output xlen_t    id_pc,
    output inst_t    id_inst,
    output opcode_t  opcode,
    output logic     illegal,
    output reg_idx_t rd,
    output reg_idx_t rs1,
    output reg_idx_t rs2,
    output xlen_t    imm
);

    fetch_stage u_fetch (
        .clk         (clk),
        .rst         (rst),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .pc          (imem_addr)
    );

    id_stage u_id (
        .clk      (clk),
        .rst      (rst),
        .redirect (redirect),
        .if_pc    (imem_addr),       // fetch pc doubles as the imem address
        .if_inst  (imem_data),
        .id_valid (id_valid),
        .id_pc    (id_pc),
        .id_inst  (id_inst),
        .opcode   (opcode),
        .illegal  (illegal),
        .rd       (rd),
        .rs1      (rs1),
        .rs2      (rs2),
        .imm      (imm)
    );

endmodule

`default_nettype wire

// ==== include/decode_model.svh ====
// testbench reference model and instruction encoders, included inside a module importing rv_decode_pkg
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// expected vector with one field set to code
function automatic opcode_t model_opcode(input int lsb, input int code);
    opcode_t v;
    v = opcode_t'(code) << lsb;
    return v;
endfunction

// expected sign-extended immediate, built by signed casts
function automatic xlen_t model_imm(input inst_t w);
    xlen_t v;
    case (w[6:0])
        OPC_JALR, OPC_LOAD, OPC_OP_IMM, OPC_OP_IMM32:
            v = xlen_t'($signed(w[31:20]));
        OPC_STORE:  v = xlen_t'($signed({w[31:25], w[11:7]}));
        OPC_BRANCH: v = xlen_t'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
        OPC_LUI, OPC_AUIPC: v = xlen_t'($signed({w[31:12], 12'h000}));
        OPC_JAL:    v = xlen_t'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
        default:    v = '0;
    endcase
    return v;
endfunction

function automatic inst_t enc_r(input logic [6:0] f7, input reg_idx_t rs2, input reg_idx_t rs1,
                                input logic [2:0] f3, input reg_idx_t rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic inst_t enc_i(input logic [11:0] im, input reg_idx_t rs1,
                                input logic [2:0] f3, input reg_idx_t rd, input logic [6:0] opc);
    return {im, rs1, f3, rd, opc};
endfunction

function automatic inst_t enc_s(input logic [11:0] im, input reg_idx_t rs2, input reg_idx_t rs1,
                                input logic [2:0] f3);
    return {im[11:5], rs2, rs1, f3, im[4:0], OPC_STORE};
endfunction

// bit 0 of a branch or jump offset is dropped
function automatic inst_t enc_b(input logic [12:0] im, input reg_idx_t rs2, input reg_idx_t rs1,
                                input logic [2:0] f3);
    return {im[12], im[10:5], rs2, rs1, f3, im[4:1], im[11], OPC_BRANCH};
endfunction

function automatic inst_t enc_u(input logic [19:0] im, input reg_idx_t rd, input logic [6:0] opc);
    return {im, rd, opc};
endfunction

function automatic inst_t enc_j(input logic [20:0] im, input reg_idx_t rd);
    return {im[20], im[10:1], im[11], im[19:12], rd, OPC_JAL};
endfunction

`endif

// ==== sim/decode_tb.sv ====
// testbench for the rv64 fetch and decode front end, compiled from build.f and run by run_sim.sh
`timescale 1ns/100ps
`default_nettype none

module decode_tb import rv_decode_pkg::*; ();

    logic     clk;
    logic     rst;
    logic     redirect;
    xlen_t    redirect_pc;
    xlen_t    imem_addr;
    inst_t    imem_data;
    logic     id_valid;
    xlen_t    id_pc;
    inst_t    id_inst;
    opcode_t  opcode;
    logic     illegal;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    xlen_t    imm;

    integer  seed;
    int      errors;
    int      tests;
    int      test_start;
    opcode_t exp_op;             // expectation for the word now on imem_data
    logic    exp_ill;
    xlen_t   exp_imm;

    logic    prev_rst = 1'b0;    // everything one cycle back
    logic    prev_redirect;
    xlen_t   prev_addr;
    xlen_t   prev_rpc;
    inst_t   prev_word;
    opcode_t prev_exp_op;
    logic    prev_exp_ill;
    xlen_t   prev_exp_imm;

    `include "decode_model.svh"

    // {funct3, major, code} for the imm / mem group
    logic [16:0] imm_tab [27] = '{
        {3'd0, OPC_JALR, OP_JALR}, {3'd0, OPC_BRANCH, OP_BEQ}, {3'd1, OPC_BRANCH, OP_BNE},
        {3'd4, OPC_BRANCH, OP_BLT}, {3'd5, OPC_BRANCH, OP_BGE}, {3'd6, OPC_BRANCH, OP_BLTU},
        {3'd7, OPC_BRANCH, OP_BGEU}, {3'd0, OPC_LOAD, OP_LB}, {3'd1, OPC_LOAD, OP_LH},
        {3'd2, OPC_LOAD, OP_LW}, {3'd4, OPC_LOAD, OP_LBU}, {3'd5, OPC_LOAD, OP_LHU},
        {3'd6, OPC_LOAD, OP_LWU}, {3'd3, OPC_LOAD, OP_LD}, {3'd0, OPC_STORE, OP_SB},
        {3'd1, OPC_STORE, OP_SH}, {3'd2, OPC_STORE, OP_SW}, {3'd3, OPC_STORE, OP_SD},
        {3'd0, OPC_OP_IMM, OP_ADDI}, {3'd2, OPC_OP_IMM, OP_SLTI}, {3'd3, OPC_OP_IMM, OP_SLTIU},
        {3'd4, OPC_OP_IMM, OP_XORI}, {3'd6, OPC_OP_IMM, OP_ORI}, {3'd7, OPC_OP_IMM, OP_ANDI},
        {3'd0, OPC_OP_IMM32, OP_ADDIW}, {3'd1, OPC_SYSTEM, OP_CSRRW}, {3'd2, OPC_SYSTEM, OP_CSRRS}
    };

    // {funct7, funct3, major, code} for the register group
    logic [24:0] reg_tab [26] = '{
        {7'h00, 3'd0, OPC_OP, REG_ADD}, {7'h20, 3'd0, OPC_OP, REG_SUB},
        {7'h00, 3'd1, OPC_OP, REG_SLL}, {7'h00, 3'd2, OPC_OP, REG_SLT},
        {7'h00, 3'd3, OPC_OP, REG_SLTU}, {7'h00, 3'd4, OPC_OP, REG_XOR},
        {7'h00, 3'd5, OPC_OP, REG_SRL}, {7'h00, 3'd6, OPC_OP, REG_OR},
        {7'h00, 3'd7, OPC_OP, REG_AND}, {7'h00, 3'd1, OPC_OP_IMM32, REG_SLLIW},
        {7'h00, 3'd5, OPC_OP_IMM32, REG_SRLIW}, {7'h20, 3'd5, OPC_OP_IMM32, REG_SRAIW},
        {7'h00, 3'd0, OPC_OP32, REG_ADDW}, {7'h20, 3'd0, OPC_OP32, REG_SUBW},
        {7'h00, 3'd1, OPC_OP32, REG_SLLW}, {7'h00, 3'd5, OPC_OP32, REG_SRLW},
        {7'h20, 3'd5, OPC_OP32, REG_SRAW}, {7'h01, 3'd0, OPC_OP, REG_MUL},
        {7'h01, 3'd4, OPC_OP, REG_DIV}, {7'h01, 3'd5, OPC_OP, REG_DIVU},
        {7'h01, 3'd7, OPC_OP, REG_REMU}, {7'h01, 3'd0, OPC_OP32, REG_MULW},
        {7'h01, 3'd4, OPC_OP32, REG_DIVW}, {7'h01, 3'd5, OPC_OP32, REG_DIVUW},
        {7'h01, 3'd6, OPC_OP32, REG_REMW}, {7'h01, 3'd7, OPC_OP32, REG_REMUW}
    };

    decode_top uut (
        .clk (clk), .rst (rst), .imem_addr (imem_addr), .imem_data (imem_data),
        .redirect (redirect), .redirect_pc (redirect_pc), .id_valid (id_valid),
        .id_pc (id_pc), .id_inst (id_inst), .opcode (opcode), .illegal (illegal),
        .rd (rd), .rs1 (rs1), .rs2 (rs2), .imm (imm)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;   // 10 ns period
    end

    always @(posedge clk) begin
        prev_rst      <= rst;
        prev_redirect <= redirect;
        prev_addr     <= imem_addr;
        prev_rpc      <= redirect_pc;
        prev_word     <= imem_data;
        prev_exp_op   <= exp_op;
        prev_exp_ill  <= exp_ill;
        prev_exp_imm  <= exp_imm;
    end

    task automatic mismatch(input string name, input logic [63:0] exp, input logic [63:0] got);
        errors++;
        $display("FAIL %s expected %h got %h at %0t", name, exp, got, $time);
    endtask

    // reset state
    assert property (@(posedge clk) prev_rst |-> imem_addr == RESET_PC)
        else mismatch("imem_addr", RESET_PC, imem_addr);
    assert property (@(posedge clk) prev_rst |-> !id_valid && !illegal)
        else mismatch("id_valid/illegal", 64'h0, {62'h0, id_valid, illegal});
    assert property (@(posedge clk) prev_rst |-> opcode == '0)
        else mismatch("opcode", 64'h0, 64'(opcode));

    // fetch pc sequence
    assert property (@(posedge clk) disable iff (rst)
        !prev_rst && !prev_redirect |-> imem_addr == prev_addr + 64'd4)
        else mismatch("imem_addr", prev_addr + 64'd4, imem_addr);
    assert property (@(posedge clk) disable iff (rst)
        !prev_rst && prev_redirect |-> imem_addr == prev_rpc)
        else mismatch("imem_addr", prev_rpc, imem_addr);

    // decode register, squash on redirect
    assert property (@(posedge clk) disable iff (rst) !prev_rst |-> id_valid == !prev_redirect)
        else mismatch("id_valid", 64'(!prev_redirect), 64'(id_valid));
    assert property (@(posedge clk) disable iff (rst) !prev_rst |-> id_pc == prev_addr)
        else mismatch("id_pc", prev_addr, id_pc);
    assert property (@(posedge clk) disable iff (rst) !prev_rst |-> id_inst == prev_word)
        else mismatch("id_inst", 64'(prev_word), 64'(id_inst));

    // decoded outputs, all zero for an empty slot
    assert property (@(posedge clk) disable iff (rst)
        !prev_rst |-> opcode == (prev_redirect ? '0 : prev_exp_op))
        else mismatch("opcode", 64'(prev_redirect ? '0 : prev_exp_op), 64'(opcode));
    assert property (@(posedge clk) disable iff (rst)
        !prev_rst |-> illegal == (!prev_redirect && prev_exp_ill))
        else mismatch("illegal", 64'(!prev_redirect && prev_exp_ill), 64'(illegal));
    assert property (@(posedge clk) disable iff (rst)
        !prev_rst |-> imm == (prev_redirect ? '0 : prev_exp_imm))
        else mismatch("imm", prev_redirect ? '0 : prev_exp_imm, imm);
    assert property (@(posedge clk) disable iff (rst)
        !prev_rst && !prev_redirect |->
        {rd, rs1, rs2} == {prev_word[11:7], prev_word[19:15], prev_word[24:20]})
        else mismatch("rd/rs1/rs2", 64'({prev_word[11:7], prev_word[19:15], prev_word[24:20]}),
                      64'({rd, rs1, rs2}));

    // present a word for one cycle with what decode should make of it
    task automatic send(input inst_t w, input opcode_t op);
        imem_data = w;
        exp_op    = op;
        exp_ill   = (op == '0) && (w != INST_NOP);
        exp_imm   = model_imm(w);
        @(negedge clk);
    endtask

    task automatic wait_valid(input int limit);
        int n;
        n = 0;
        while (!id_valid && n < limit) begin
            n++;
            @(negedge clk);
        end
        if (!id_valid) begin
            errors++;
            $display("timeout: id_valid did not return after %0d cycles", limit);
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("[%s] done, %0d new errors", name, errors - test_start);
        test_start = errors;
    endtask

    initial begin
        #100000;                 // whole-run limit
        $display("timeout: simulation did not reach its end");
        $display("test failed");
        $finish;
    end

    initial begin
        logic [31:0] r;
        int          i;
        rst         = 1'b1;
        redirect    = 1'b0;
        redirect_pc = '0;
        imem_data   = INST_NOP;
        exp_op      = '0;
        exp_ill     = 1'b0;
        exp_imm     = '0;
        seed        = 32'hf55e_f650;
        errors      = 0;
        tests       = 0;
        test_start  = 0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        end_test("reset");

        wait_valid(4);
        for (i = 0; i < 16; i++) begin
            r = $random(seed);
            send(enc_i(r[31:20], r[19:15], 3'd0, r[11:7], OPC_OP_IMM),
                 model_opcode(OPF_IMM_MEM_LSB, int'(OP_ADDI)));
        end
        end_test("sequential fetch");

        for (i = 0; i < 27; i++) begin
            r = $random(seed);
            send({r[31:15], imm_tab[i][16:14], r[11:7], imm_tab[i][13:7]},
                 model_opcode(OPF_IMM_MEM_LSB, int'(imm_tab[i][6:0])));
        end
        for (i = 0; i < 26; i++) begin
            r = $random(seed);
            send(enc_r(reg_tab[i][24:18], r[24:20], r[19:15], reg_tab[i][17:15], r[11:7],
                       reg_tab[i][14:8]), model_opcode(OPF_REG_LSB, int'(reg_tab[i][7:0])));
        end
        r = $random(seed);
        send({r[31:7], OPC_LUI}, model_opcode(OPF_UPPER_LSB, int'(UP_LUI)));
        send({r[24:0], OPC_AUIPC}, model_opcode(OPF_UPPER_LSB, int'(UP_AUIPC)));
        send({r[28:4], OPC_JAL}, model_opcode(OPF_UPPER_LSB, int'(UP_JAL)));
        send({6'h00, r[5:0], r[19:15], 3'd1, r[11:7], OPC_OP_IMM},
             model_opcode(OPF_SHIFTI_LSB, int'(SH_SLLI)));
        send({6'h00, r[5:0], r[19:15], 3'd5, r[11:7], OPC_OP_IMM},
             model_opcode(OPF_SHIFTI_LSB, int'(SH_SRLI)));
        send({6'h10, r[5:0], r[19:15], 3'd5, r[11:7], OPC_OP_IMM},
             model_opcode(OPF_SHIFTI_LSB, int'(SH_SRAI)));
        send(INST_ECALL, model_opcode(OPF_SYS_LSB, int'(SYS_ECALL)));
        send(INST_MRET, model_opcode(OPF_SYS_LSB, int'(SYS_MRET)));
        send(INST_EBREAK, model_opcode(OPF_EBREAK, 1));
        end_test("opcode classification");

        for (i = 0; i < 10; i++) begin
            r     = $random(seed);
            r[31] = i[0];        // alternate the sign
            send(enc_i(r[31:20], r[19:15], 3'd0, r[11:7], OPC_OP_IMM),
                 model_opcode(OPF_IMM_MEM_LSB, int'(OP_ADDI)));
            send(enc_s(r[31:20], r[24:20], r[19:15], 3'd3),
                 model_opcode(OPF_IMM_MEM_LSB, int'(OP_SD)));
            send(enc_b(r[31:19], r[24:20], r[19:15], 3'd0),
                 model_opcode(OPF_IMM_MEM_LSB, int'(OP_BEQ)));
            send(enc_u(r[31:12], r[11:7], OPC_LUI), model_opcode(OPF_UPPER_LSB, int'(UP_LUI)));
            send(enc_j(r[31:11], r[11:7]), model_opcode(OPF_UPPER_LSB, int'(UP_JAL)));
        end
        send(enc_r(7'h00, r[24:20], r[19:15], 3'd0, r[11:7], OPC_OP),
             model_opcode(OPF_REG_LSB, int'(REG_ADD)));   // r-type has no immediate
        end_test("immediates");

        send(32'h0000_007f, '0);                          // undefined major opcode
        send(enc_r(7'h02, 5'd3, 5'd2, 3'd6, 5'd1, OPC_OP), '0);   // rem, reserved funct7
        send(INST_NOP, '0);                               // valid zero word is not illegal
        end_test("illegal detection");

        for (i = 0; i < 4; i++) begin
            redirect    = 1'b1;
            redirect_pc = {$random(seed), $random(seed)} & ~64'h3;
            send(enc_r(7'h00, 5'd4, 5'd5, 3'd0, 5'd6, OPC_OP),
                 model_opcode(OPF_REG_LSB, int'(REG_ADD)));   // wrong-path slot
            redirect = 1'b0;
            wait_valid(4);
            send(enc_i(12'h123, 5'd1, 3'd0, 5'd2, OPC_OP_IMM),
                 model_opcode(OPF_IMM_MEM_LSB, int'(OP_ADDI)));
        end
        repeat (2) @(negedge clk);   // let the last slot be checked
        end_test("redirect");

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
verilog/rv_decode_pkg.sv
+incdir+include
verilog/fetch_stage.sv
verilog/inst_decoder.sv
verilog/imm_gen.sv
verilog/id_stage.sv
verilog/decode_top.sv
sim/decode_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the decode front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module decode_tb -o decode_sim

./obj_dir/decode_sim 2>&1 | tee sim.log

if grep -q "test failed" sim.log || ! grep -q "test passed" sim.log; then
    echo "simulation FAILED, see sim.log"
    exit 1
fi
echo "simulation ok"
